// File: sim/program_input.hex
// Program words from address 0, then dead, then expected store address and data
// pairs, then the expected store count, then dead again
AD00 BD01 A134 B112 A211 B201 0312 93D0
1412 94D1 2512 95D2 3612 96D3 4714 97D4
A921 B984 5893 98D5 6A94 9AD6 7B99 9BD7
ACFF BC7F 0EC1 AF20 BF01 9EF0 1E9C 9EF1
A055 90F2 91F3 AA2B BA01 84AE 94F4 1011
C201 92F5 C001 92F5 1021 C601 92F6 C401
92F6 CA01 92F7 C801 92F7 CC01 93DF 00CC
CC01 93DF CE01 93DF C401 93DF A682 DE60
93DF E700 97D1 F000
DEAD
// Compute results
0100 1345
0102 1123
0104 1325
0106 0058
0108 2340
010A F084
010C 1842
010E 8742
// Saturating add and sub
0120 7FFF
0122 8000
// R0 write dropped
0124 0000
// Store and load round trip
0126 1234
0128 1234
// Branch markers
012A 0111
012C 0111
012E 0111
00FE 1345
// PCS return address
0102 0084
// Store count
0012
DEAD

// File: tb.f
verilog/cpu_pkg.sv
verilog/control.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pc_counter.sv
verilog/cycle_fsm.sv
verilog/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_cpu \
    -Mdir obj_dir \
    -o vtb_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/vtb_cpu > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// File: sim/tb_cpu.sv
// Processor testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

    localparam int FILE_WORDS   = 512;
    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 20;
    localparam cpu_pkg::word_t MARKER = 16'hdead;

    logic             clk;
    logic             rst;
    cpu_pkg::wb_req_t wb;
    cpu_pkg::word_t   wb_dat_i;
    logic             wb_ack;
    logic             halted;

    cpu_pkg::word_t file_img [FILE_WORDS];
    cpu_pkg::word_t mem [MEM_WORDS];
    cpu_pkg::word_t exp_adr [$];
    cpu_pkg::word_t exp_dat [$];
    int             prog_len;
    int             exp_count;
    int             store_count;
    int             pass_count;
    int             fail_count;
    int             cycle_count;
    int             timeout_limit;
    int             waits_left;
    logic [31:0]    lcg_state;
    logic           bus_after_halt;

    cpu_top #(
        .RESET_PC (16'h0000)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Unused memory gets a pattern built from all eight word address bits
    function automatic cpu_pkg::word_t fill_word(input int addr);
        return {addr[7:0] ^ 8'h5a, ~addr[7:0]};
    endfunction

    task automatic report_test(input string name, input logic ok);
        if (ok) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    // Image layout is program, marker, address and data pairs, count, marker
    task automatic load_image();
        int first;
        int last;
        first = -1;
        last  = -1;
        for (int i = 0; i < FILE_WORDS; i++)
            file_img[i] = '0;
        $readmemh("sim/program_input.hex", file_img);
        for (int i = 0; i < FILE_WORDS; i++) begin
            if (file_img[i] == MARKER && first < 0)
                first = i;
            else if (file_img[i] == MARKER && last < 0)
                last = i;
        end
        assert (first > 0 && last > first + 1 && first <= MEM_WORDS) else begin
            $display("data file has no valid marker words");
            fail_count++;
            first = 0;
            last  = 1;
        end
        prog_len  = first;
        exp_count = int'(file_img[last - 1]);
        for (int i = first + 1; i + 1 < last - 1; i += 2) begin
            exp_adr.push_back(file_img[i]);
            exp_dat.push_back(file_img[i + 1]);
        end
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (i < prog_len) ? file_img[i] : fill_word(i);
    endtask

    // Each store is matched in order against the next expected record
    task automatic check_store(input cpu_pkg::word_t adr, input cpu_pkg::word_t dat);
        cpu_pkg::word_t ea;
        cpu_pkg::word_t ed;
        logic           ok;
        ok = 1'b1;
        store_count++;
        if (exp_adr.size() == 0) begin
            $display("store to %h with %h was not expected", adr, dat);
            ok = 1'b0;
        end else begin
            ea = exp_adr.pop_front();
            ed = exp_dat.pop_front();
            assert (adr == ea) else begin
                $display("[ERROR] wb.adr expected %h actual %h", ea, adr);
                ok = 1'b0;
            end
            assert (dat == ed) else begin
                $display("[ERROR] wb.dat expected %h actual %h", ed, dat);
                ok = 1'b0;
            end
        end
        report_test($sformatf("store %0d", store_count), ok);
    endtask

    // The memory model acks after a random 0 to 3 wait states
    initial begin
        wb_ack         = 1'b0;
        wb_dat_i       = '0;
        bus_after_halt = 1'b0;
        lcg_state      = 32'd63;
        waits_left     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (halted && wb.cyc)
                bus_after_halt = 1'b1;
            if (wb_ack) begin
                // The handshake completed at this edge
                wb_ack     = 1'b0;
                lcg_state  = lcg_next(lcg_state);
                waits_left = int'(lcg_state[17:16]);
            end else if (wb.cyc && wb.stb) begin
                if (waits_left > 0) begin
                    waits_left--;
                end else begin
                    if (wb.we) begin
                        mem[wb.adr[8:1]] = wb.dat;
                        check_store(wb.adr, wb.dat);
                    end else begin
                        wb_dat_i = mem[wb.adr[8:1]];
                    end
                    wb_ack = 1'b1;
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        pass_count  = 0;
        fail_count  = 0;
        store_count = 0;
        cycle_count = 0;
        load_image();
        timeout_limit = 40 * prog_len + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!halted && cycle_count < timeout_limit) begin
            @(posedge clk);
            #1;
            cycle_count++;
        end
        assert (halted) else
            $display("timeout before halt");
        report_test("halt", halted);
        if (halted) begin
            // Watch the bus for a while after the halt
            repeat (IDLE_CYCLES) @(posedge clk);
            #1;
            assert (!bus_after_halt) else
                $display("a bus cycle started after halt");
            report_test("bus idle after halt", !bus_after_halt);
            assert (store_count == exp_count) else
                $display("[ERROR] store_count expected %h actual %h", exp_count, store_count);
            report_test("store count", store_count == exp_count);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/cpu_checker.sv
// Wishbone protocol checker
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
    input wire                   clk,
    input wire                   rst,
    input wire cpu_pkg::wb_req_t wb,
    input wire                   wb_ack,
    input wire                   halted
);

    // Strobe is only valid inside a cycle
    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        wb.stb |-> wb.cyc)
        else $error("stb high without cyc");

    // A waiting request keeps its address, direction and data
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.we)
                                 && $stable(wb.dat)))
        else $error("request changed before ack");

    idle_in_reset: assert property (@(posedge clk)
        rst |=> !wb.cyc)
        else $error("cyc high after a reset cycle");

    idle_when_halted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !wb.cyc)
        else $error("cyc high while halted");

endmodule

bind cpu_top cpu_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .wb     (wb),
    .wb_ack (wb_ack),
    .halted (halted)
);

`default_nettype wire

// File: verilog/cpu_top.sv
// Multicycle processor top
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
    input  wire                 clk,
    input  wire                 rst,
    output cpu_pkg::wb_req_t    wb,
    input  wire cpu_pkg::word_t wb_dat_i,
    input  wire                 wb_ack,
    output logic                halted
);

    cpu_pkg::word_t     instr;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::reg_addr_t addr_a;
    cpu_pkg::reg_addr_t addr_b;
    cpu_pkg::word_t     data_a;
    cpu_pkg::word_t     data_b;
    cpu_pkg::word_t     alu_a;
    cpu_pkg::word_t     alu_b;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::word_t     mem_offset;
    cpu_pkg::word_t     br_offset;
    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     pc_seq;
    cpu_pkg::word_t     reg_wdata;
    logic               byte_op;
    logic               mem_op;
    logic               cond_met;
    logic               advance;
    logic               flag_en;
    logic               reg_we;

    assign byte_op = (ctrl.alu_op == cpu_pkg::ALU_LLB) | (ctrl.alu_op == cpu_pkg::ALU_LHB);
    assign mem_op  = ctrl.mem_read | ctrl.mem_write;

    // LLB and LHB modify rd in place, SW stores rd
    assign addr_a = byte_op        ? instr[11:8] : instr[7:4];
    assign addr_b = ctrl.mem_write ? instr[11:8] : instr[3:0];

    // Word offsets become byte offsets by a shift left of one
    assign mem_offset = {{11{instr[3]}}, instr[3:0], 1'b0};
    assign br_offset  = {{6{instr[8]}}, instr[8:0], 1'b0};

    // Memory base is forced to an even byte address
    assign alu_a = mem_op ? {data_a[15:1], 1'b0} : data_a;
    assign alu_b = !ctrl.alu_src ? data_b                  :
                   mem_op        ? mem_offset              :
                   byte_op       ? {8'h00, instr[7:0]}     : {12'h000, instr[3:0]};

    control u_control (
        .opcode (instr[15:12]),
        .ctrl   (ctrl)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .addr_a  (addr_a),
        .addr_b  (addr_b),
        .wr_en   (reg_we),
        .wr_addr (instr[11:8]),
        .wr_data (reg_wdata),
        .data_a  (data_a),
        .data_b  (data_b)
    );

    alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .a        (alu_a),
        .b        (alu_b),
        .op       (ctrl.alu_op),
        .flag_en  (flag_en),
        .cond     (instr[11:9]),
        .result   (alu_result),
        .cond_met (cond_met)
    );

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc_counter (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .pc_sel   (ctrl.pc_sel),
        .cond_met (cond_met),
        .offset   (br_offset),
        .target   (data_a),
        .pc       (pc),
        .pc_seq   (pc_seq)
    );

    cycle_fsm u_cycle_fsm (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_result (alu_result),
        .store_data (data_b),
        .pc_seq     (pc_seq),
        .wb         (wb),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .instr      (instr),
        .advance    (advance),
        .flag_en    (flag_en),
        .reg_we     (reg_we),
        .reg_wdata  (reg_wdata),
        .halted     (halted)
    );

endmodule

`default_nettype wire

// File: verilog/cycle_fsm.sv
// Instruction cycle sequencer
`timescale 1ns/1ns
`default_nettype none

module cycle_fsm (
    input  wire                 clk,
    input  wire                 rst,
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire cpu_pkg::word_t pc,
    input  wire cpu_pkg::word_t alu_result,
    input  wire cpu_pkg::word_t store_data,
    input  wire cpu_pkg::word_t pc_seq,
    output cpu_pkg::wb_req_t    wb,
    input  wire cpu_pkg::word_t wb_dat_i,
    input  wire                 wb_ack,
    output cpu_pkg::word_t      instr,
    output logic                advance,
    output logic                flag_en,
    output logic                reg_we,
    output cpu_pkg::word_t      reg_wdata,
    output logic                halted
);

    cpu_pkg::cpu_state_t state;
    cpu_pkg::word_t      mem_data;
    logic                is_pcs;
    logic                is_mem;

    // PCS has no field of its own in the control word
    assign is_pcs = (instr[15:12] == cpu_pkg::OP_PCS);
    assign is_mem = ctrl.mem_read | ctrl.mem_write;

    // The bus request is registered, so cyc and stb drop the cycle after ack
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cpu_pkg::FETCH;
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
            wb.we  <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::FETCH: begin
                    // First cycle in FETCH raises the request at the current PC
                    if (!wb.cyc) begin
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                        wb.we  <= 1'b0;
                        wb.adr <= pc;
                    end else if (wb_ack) begin
                        wb.cyc <= 1'b0;
                        wb.stb <= 1'b0;
                        state  <= cpu_pkg::DECODE;
                    end
                end
                cpu_pkg::DECODE: state <= cpu_pkg::EXECUTE;
                cpu_pkg::EXECUTE: begin
                    // Data access starts straight away at the computed address
                    if (is_mem) begin
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                        wb.we  <= ctrl.mem_write;
                        wb.adr <= alu_result;
                        wb.dat <= store_data;
                        state  <= cpu_pkg::MEMORY;
                    end else if (ctrl.pc_sel == cpu_pkg::PC_HALT) begin
                        state <= cpu_pkg::HALT;
                    end else begin
                        state <= cpu_pkg::FETCH;
                    end
                end
                cpu_pkg::MEMORY: begin
                    if (wb_ack) begin
                        wb.cyc <= 1'b0;
                        wb.stb <= 1'b0;
                        state  <= ctrl.mem_read ? cpu_pkg::WRITEBACK : cpu_pkg::FETCH;
                    end
                end
                cpu_pkg::WRITEBACK: state <= cpu_pkg::FETCH;
                default: state <= cpu_pkg::HALT;
            endcase
        end
    end

    // Instruction and load data are captured with the ack that returns them
    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::FETCH) && wb.cyc && wb_ack)
            instr <= wb_dat_i;
        if ((state == cpu_pkg::MEMORY) && wb_ack)
            mem_data <= wb_dat_i;
    end

    assign advance = (state == cpu_pkg::EXECUTE);
    assign halted  = (state == cpu_pkg::HALT);

    // Only plain compute ops touch the flags, not LW, SW, PCS or branches
    assign flag_en = advance & ctrl.reg_write & ~ctrl.mem_to_reg & ~is_pcs;

    // LW writes in WRITEBACK, every other register write lands in EXECUTE
    assign reg_we = (advance & ctrl.reg_write & ~ctrl.mem_to_reg)
                  | (state == cpu_pkg::WRITEBACK);

    assign reg_wdata = ctrl.mem_to_reg ? mem_data :
                       is_pcs          ? pc_seq   : alu_result;

endmodule

`default_nettype wire

// File: verilog/pc_counter.sv
// Program counter
`timescale 1ns/1ns
`default_nettype none

module pc_counter #(
    parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   advance,
    input  wire cpu_pkg::pc_sel_t pc_sel,
    input  wire                   cond_met,
    input  wire cpu_pkg::word_t   offset,
    input  wire cpu_pkg::word_t   target,
    output cpu_pkg::word_t        pc,
    output cpu_pkg::word_t        pc_seq
);

    cpu_pkg::word_t pc_next;

    // Words are two bytes wide
    assign pc_seq = pc + 16'd2;

    // Untaken branches and HLT fall through to PC+2
    always_comb begin
        pc_next = pc_seq;
        if (cond_met) begin
            if (pc_sel == cpu_pkg::PC_REL)
                pc_next = pc_seq + offset;
            else if (pc_sel == cpu_pkg::PC_REG)
                pc_next = target;
        end
    end

    // Loads only once per instruction, at the edge that ends EXECUTE
    always_ff @(posedge clk) begin
        if (rst)
            pc <= RESET_PC;
        else if (advance)
            pc <= pc_next;
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// Sixteen entry register file
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cpu_pkg::reg_addr_t addr_a,
    input  wire cpu_pkg::reg_addr_t addr_b,
    input  wire                     wr_en,
    input  wire cpu_pkg::reg_addr_t wr_addr,
    input  wire cpu_pkg::word_t     wr_data,
    output cpu_pkg::word_t          data_a,
    output cpu_pkg::word_t          data_b
);

    cpu_pkg::word_t regs [16];

    // Writes to R0 are dropped, so it holds its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Both read ports are combinational, and R0 reads zero
    assign data_a = (addr_a == '0) ? '0 : regs[addr_a];
    assign data_b = (addr_b == '0) ? '0 : regs[addr_b];

endmodule

`default_nettype wire

// File: verilog/alu.sv
// Arithmetic and logic unit
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire                   clk,
    input  wire                   rst,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire cpu_pkg::alu_op_t op,
    input  wire                   flag_en,
    input  wire cpu_pkg::cond_t   cond,
    output cpu_pkg::word_t        result,
    output logic                  cond_met
);

    cpu_pkg::word_t  sum;
    cpu_pkg::word_t  diff;
    cpu_pkg::word_t  paddsb;
    logic            add_ovf;
    logic            sub_ovf;
    logic [9:0]      red_sum;
    logic [31:0]     rot;
    logic [4:0]      lane_sum [4];
    logic            sets_z;
    logic            sets_nv;
    cpu_pkg::flags_t flags;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow: operand signs allow it and the result sign disagrees
    assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
    assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

    // Reduction over all four bytes, each one sign extended to 10 bits
    assign red_sum = {{2{a[15]}}, a[15:8]} + {{2{a[7]}}, a[7:0]}
                   + {{2{b[15]}}, b[15:8]} + {{2{b[7]}}, b[7:0]};

    // Rotating the doubled word right leaves the rotated value in the low half
    assign rot = {a, a} >> b[3:0];

    // Four independent nibble adds that clamp to 7 or -8
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_sum[i] = {a[4*i+3], a[4*i +: 4]} + {b[4*i+3], b[4*i +: 4]};
            if (lane_sum[i][4] != lane_sum[i][3])
                paddsb[4*i +: 4] = lane_sum[i][4] ? 4'b1000 : 4'b0111;
            else
                paddsb[4*i +: 4] = lane_sum[i][3:0];
        end
    end

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    result = add_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : sum;
            cpu_pkg::ALU_SUB:    result = sub_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : diff;
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_RED:    result = {{6{red_sum[9]}}, red_sum};
            cpu_pkg::ALU_SLL:    result = a << b[3:0];
            cpu_pkg::ALU_SRA:    result = $signed(a) >>> b[3:0];
            cpu_pkg::ALU_ROR:    result = rot[15:0];
            cpu_pkg::ALU_PADDSB: result = paddsb;
            cpu_pkg::ALU_LLB:    result = {a[15:8], b[7:0]};
            cpu_pkg::ALU_LHB:    result = {b[7:0], a[7:0]};
            default:             result = sum;
        endcase
    end

    // N and V follow ADD and SUB only, Z also follows XOR and the shifts
    assign sets_nv = (op == cpu_pkg::ALU_ADD) || (op == cpu_pkg::ALU_SUB);
    assign sets_z  = sets_nv || (op == cpu_pkg::ALU_XOR) || (op == cpu_pkg::ALU_SLL)
                  || (op == cpu_pkg::ALU_SRA) || (op == cpu_pkg::ALU_ROR);

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flag_en) begin
            if (sets_z)
                flags.z <= (result == '0);
            if (sets_nv) begin
                flags.n <= result[15];
                flags.v <= (op == cpu_pkg::ALU_SUB) ? sub_ovf : add_ovf;
            end
        end
    end

    // Branch condition, evaluated against the flags left by earlier instructions
    always_comb begin
        case (cond)
            3'b000:  cond_met = ~flags.z;
            3'b001:  cond_met = flags.z;
            3'b010:  cond_met = ~flags.z & ~flags.n;
            3'b011:  cond_met = flags.n;
            3'b100:  cond_met = flags.z | ~flags.n;
            3'b101:  cond_met = flags.z | flags.n;
            3'b110:  cond_met = flags.v;
            default: cond_met = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/control.sv
// Opcode decoder
`timescale 1ns/1ns
`default_nettype none

module control (
    input  wire cpu_pkg::opcode_t opcode,
    output cpu_pkg::ctrl_t        ctrl
);

    // Register write for all compute ops (0xxx), LW, LLB, LHB and PCS
    assign ctrl.reg_write = ~opcode[3]
                          | (opcode == cpu_pkg::OP_LW)
                          | (opcode == cpu_pkg::OP_LLB)
                          | (opcode == cpu_pkg::OP_LHB)
                          | (opcode == cpu_pkg::OP_PCS);

    // Second ALU operand comes from the instruction instead of register port B
    // Shifts take a 4-bit amount, LW and SW an offset, LLB and LHB a byte
    assign ctrl.alu_src = (opcode == cpu_pkg::OP_SLL)
                        | (opcode == cpu_pkg::OP_SRA)
                        | (opcode == cpu_pkg::OP_ROR)
                        | (opcode == cpu_pkg::OP_LW)
                        | (opcode == cpu_pkg::OP_SW)
                        | (opcode == cpu_pkg::OP_LLB)
                        | (opcode == cpu_pkg::OP_LHB);

    // Only LW reads memory, and only LW writes memory data back
    assign ctrl.mem_read   = (opcode == cpu_pkg::OP_LW);
    assign ctrl.mem_to_reg = (opcode == cpu_pkg::OP_LW);

    // Only SW writes memory
    assign ctrl.mem_write = (opcode == cpu_pkg::OP_SW);

    // Compute opcodes map straight onto the ALU code of the same value
    // LW and SW use ADD for the effective address, as does everything unlisted
    always_comb begin
        case (opcode)
            cpu_pkg::OP_ADD:    ctrl.alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SUB:    ctrl.alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_XOR:    ctrl.alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_RED:    ctrl.alu_op = cpu_pkg::ALU_RED;
            cpu_pkg::OP_SLL:    ctrl.alu_op = cpu_pkg::ALU_SLL;
            cpu_pkg::OP_SRA:    ctrl.alu_op = cpu_pkg::ALU_SRA;
            cpu_pkg::OP_ROR:    ctrl.alu_op = cpu_pkg::ALU_ROR;
            cpu_pkg::OP_PADDSB: ctrl.alu_op = cpu_pkg::ALU_PADDSB;
            cpu_pkg::OP_LLB:    ctrl.alu_op = cpu_pkg::ALU_LLB;
            cpu_pkg::OP_LHB:    ctrl.alu_op = cpu_pkg::ALU_LHB;
            default:            ctrl.alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    // PC source: PC+2 by default, PC+2+imm for B, rs for BR, halt for HLT
    always_comb begin
        case (opcode)
            cpu_pkg::OP_B:   ctrl.pc_sel = cpu_pkg::PC_REL;
            cpu_pkg::OP_BR:  ctrl.pc_sel = cpu_pkg::PC_REG;
            cpu_pkg::OP_HLT: ctrl.pc_sel = cpu_pkg::PC_HALT;
            default:         ctrl.pc_sel = cpu_pkg::PC_SEQ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
// Processor shared types
`default_nettype none

package cpu_pkg;

    // Data word, also used for byte addresses
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  pc_sel_t;
    // Branch condition taken from instruction bits 11..9
    typedef logic [2:0]  cond_t;

    // Opcodes live in instruction bits 15..12
    localparam opcode_t OP_ADD    = 4'b0000;
    localparam opcode_t OP_SUB    = 4'b0001;
    localparam opcode_t OP_XOR    = 4'b0010;
    localparam opcode_t OP_RED    = 4'b0011;
    localparam opcode_t OP_SLL    = 4'b0100;
    localparam opcode_t OP_SRA    = 4'b0101;
    localparam opcode_t OP_ROR    = 4'b0110;
    localparam opcode_t OP_PADDSB = 4'b0111;
    localparam opcode_t OP_LW     = 4'b1000;
    localparam opcode_t OP_SW     = 4'b1001;
    localparam opcode_t OP_LLB    = 4'b1010;
    localparam opcode_t OP_LHB    = 4'b1011;
    localparam opcode_t OP_B      = 4'b1100;
    localparam opcode_t OP_BR     = 4'b1101;
    localparam opcode_t OP_PCS    = 4'b1110;
    localparam opcode_t OP_HLT    = 4'b1111;

    // ALU operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_XOR    = 4'd2;
    localparam alu_op_t ALU_RED    = 4'd3;
    localparam alu_op_t ALU_SLL    = 4'd4;
    localparam alu_op_t ALU_SRA    = 4'd5;
    localparam alu_op_t ALU_ROR    = 4'd6;
    localparam alu_op_t ALU_PADDSB = 4'd7;
    localparam alu_op_t ALU_LLB    = 4'd8;
    localparam alu_op_t ALU_LHB    = 4'd9;

    // Next PC selection
    localparam pc_sel_t PC_SEQ  = 2'd0;
    localparam pc_sel_t PC_REL  = 2'd1;
    localparam pc_sel_t PC_REG  = 2'd2;
    localparam pc_sel_t PC_HALT = 2'd3;

    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flags_t;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        alu_op_t alu_op;
        pc_sel_t pc_sel;
    } ctrl_t;

    // Wishbone classic master request
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } cpu_state_t;

endpackage

`default_nettype wire
